/* verilog/sm83_consts.svh */
// SM83 register section constants for pair codes, mux selects, reset values and opcodes
`ifndef SM83_CONSTS_SVH
`define SM83_CONSTS_SVH

// Register pair codes, as in opcode field p
`define SM83_PAIR_BC 2'd0
`define SM83_PAIR_DE 2'd1
`define SM83_PAIR_HL 2'd2
`define SM83_PAIR_SP 2'd3

`define SM83_IDU_SRC_PC   2'd0   // Increment/decrement source select
`define SM83_IDU_SRC_SP   2'd1
`define SM83_IDU_SRC_PAIR 2'd2

`define SM83_SRC_DL  1'b0        // Register write from the data latch
`define SM83_SRC_RDA 1'b1        // Register write from read port A

`define SM83_SP_RESET 16'hfffe
`define SM83_PC_RESET 16'h0000

`define SM83_OP_HALT   8'h76
`define SM83_OP_JP     8'hc3
`define SM83_OP_LDSPHL 8'hf9

`endif

/* verilog/sm83_pkg.sv */
// SM83 register section types for the opcode views and the datapath selects
package sm83_pkg;

	// Opcode split as x:y:z
	typedef struct packed {
		logic [1:0] x;
		logic [2:0] y;
		logic [2:0] z;
	} op_xyz_t;

	// Opcode split as x:p:q:z, p names a register pair
	typedef struct packed {
		logic [1:0] x;
		logic [1:0] p;
		logic       q;
		logic [2:0] z;
	} op_xpqz_t;

	typedef union packed {
		op_xyz_t  xyz;
		op_xpqz_t xpqz;
	} opcode_t;

	typedef enum logic [2:0] {
		reg_b, reg_c, reg_d, reg_e, reg_h, reg_l, reg_hl_mem, reg_a
	} reg_sel_t;   // Opcode order

	typedef enum logic [1:0] {addr_pc, addr_hl, addr_wz} addr_sel_t;

	typedef enum logic [1:0] {idu_pass, idu_inc, idu_dec} idu_op_t;

endpackage

/* verilog/sm83_regfile.sv */
// SM83 register file holding IR and the general registers, with two read ports
`include "sm83_consts.svh"

module sm83_regfile (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               ir_ld,
	input  logic [7:0]         dl,
	input  logic               reg_ld,
	input  sm83_pkg::reg_sel_t reg_dst,
	input  logic               reg_src_sel,
	input  sm83_pkg::reg_sel_t rd_sel_a,
	input  sm83_pkg::reg_sel_t rd_sel_b,
	input  logic               pair_ld,
	input  logic [1:0]         pair_sel,
	input  logic [15:0]        pair_data,
	output sm83_pkg::opcode_t  ir,
	output logic [7:0]         rd_data_a,
	output logic [7:0]         rd_data_b,
	output logic [15:0]        pair_q,
	output logic [15:0]        hl,
	output logic [7:0]         a_out
);

	logic [7:0] ir_q;
	logic [7:0] r_a;
	logic [7:0] r_b;
	logic [7:0] r_c;
	logic [7:0] r_d;
	logic [7:0] r_e;
	logic [7:0] r_h;
	logic [7:0] r_l;
	logic [7:0] wr_byte;

	function automatic logic [7:0] read_reg(input sm83_pkg::reg_sel_t sel);
		case (sel)
			sm83_pkg::reg_b: read_reg = r_b;
			sm83_pkg::reg_c: read_reg = r_c;
			sm83_pkg::reg_d: read_reg = r_d;
			sm83_pkg::reg_e: read_reg = r_e;
			sm83_pkg::reg_h: read_reg = r_h;
			sm83_pkg::reg_l: read_reg = r_l;
			sm83_pkg::reg_a: read_reg = r_a;
			default:         read_reg = 8'h00;   // (HL) is memory, not a register
		endcase
	endfunction

	always_comb begin
		rd_data_a = read_reg(rd_sel_a);
		rd_data_b = read_reg(rd_sel_b);   // Store data
		case (pair_sel)
			`SM83_PAIR_BC: pair_q = {r_b, r_c};
			`SM83_PAIR_DE: pair_q = {r_d, r_e};
			default:       pair_q = {r_h, r_l};
		endcase
	end

	assign ir      = ir_ld ? dl : ir_q;   // Opcode visible in the load cycle
	assign wr_byte = (reg_src_sel == `SM83_SRC_DL) ? dl : rd_data_a;
	assign hl      = {r_h, r_l};
	assign a_out   = r_a;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ir_q <= '0;
			r_a  <= '0;
			r_b  <= '0;
			r_c  <= '0;
			r_d  <= '0;
			r_e  <= '0;
			r_h  <= '0;
			r_l  <= '0;
		end else begin
			if (ir_ld)
				ir_q <= dl;
			if (reg_ld) begin
				case (reg_dst)
					sm83_pkg::reg_b: r_b <= wr_byte;
					sm83_pkg::reg_c: r_c <= wr_byte;
					sm83_pkg::reg_d: r_d <= wr_byte;
					sm83_pkg::reg_e: r_e <= wr_byte;
					sm83_pkg::reg_h: r_h <= wr_byte;
					sm83_pkg::reg_l: r_l <= wr_byte;
					sm83_pkg::reg_a: r_a <= wr_byte;
					default: ;
				endcase
			end
			if (pair_ld) begin
				case (pair_sel)
					`SM83_PAIR_BC: {r_b, r_c} <= pair_data;
					`SM83_PAIR_DE: {r_d, r_e} <= pair_data;
					`SM83_PAIR_HL: {r_h, r_l} <= pair_data;
					default: ;   // SP is kept in sm83_sp_pc
				endcase
			end
		end
	end

endmodule

/* verilog/sm83_temp_regs.sv */
// SM83 Z and W temporary registers, loaded from the data latch for 16-bit operands
module sm83_temp_regs (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        z_ld,
	input  logic        w_ld,
	input  logic [7:0]  dl,
	output logic [15:0] wz
);

	logic [7:0] z_q;   // Low operand byte
	logic [7:0] w_q;   // High operand byte

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			z_q <= '0;
			w_q <= '0;
		end else begin
			if (z_ld)
				z_q <= dl;
			if (w_ld)
				w_q <= dl;
		end
	end

	// W is the high half
	assign wz = {w_q, z_q};

endmodule

/* verilog/sm83_sp_pc.sv */
// SM83 stack pointer and program counter, with the address bus source select
`include "sm83_consts.svh"

module sm83_sp_pc (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                pc_ld_idu,
	input  logic                pc_ld_wz,
	input  logic                sp_ld_idu,
	input  logic                sp_ld_hl,
	input  sm83_pkg::addr_sel_t addr_sel,
	input  logic [15:0]         idu_result,
	input  logic [15:0]         wz,
	input  logic [15:0]         hl,
	output logic [15:0]         pc,
	output logic [15:0]         sp,
	output logic [15:0]         addr
);

	logic [15:0] pc_q;
	logic [15:0] sp_q;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc_q <= `SM83_PC_RESET;
			sp_q <= `SM83_SP_RESET;
		end else begin
			if (pc_ld_wz)
				pc_q <= wz;           // Jump target
			else if (pc_ld_idu)
				pc_q <= idu_result;   // Next byte

			if (sp_ld_hl)
				sp_q <= hl;
			else if (sp_ld_idu)
				sp_q <= idu_result;
		end
	end

	always_comb begin
		case (addr_sel)
			sm83_pkg::addr_hl: addr = hl;
			sm83_pkg::addr_wz: addr = wz;
			default:           addr = pc_q;
		endcase
	end

	assign pc = pc_q;
	assign sp = sp_q;

endmodule

/* verilog/sm83_idu.sv */
// SM83 16-bit increment/decrement unit over PC, SP or a register pair
`include "sm83_consts.svh"

module sm83_idu (
	input  sm83_pkg::idu_op_t idu_op,
	input  logic [15:0]       pc,
	input  logic [15:0]       sp,
	input  logic [15:0]       pair_q,
	input  logic [1:0]        idu_src,
	output logic [15:0]       result
);

	logic [15:0] src;

	always_comb begin
		case (idu_src)
			`SM83_IDU_SRC_SP:   src = sp;
			`SM83_IDU_SRC_PAIR: src = pair_q;
			default:            src = pc;
		endcase
	end

	// Wraps at 16 bits, no carry out
	always_comb begin
		case (idu_op)
			sm83_pkg::idu_inc: result = src + 16'd1;
			sm83_pkg::idu_dec: result = src - 16'd1;
			default:           result = src;
		endcase
	end

endmodule

/* verilog/sm83_control.sv */
// SM83 step sequencer and opcode decoder driving the register section strobes
`include "sm83_consts.svh"

module sm83_control (
	input  logic                clk,
	input  logic                rst_n,
	input  sm83_pkg::opcode_t   ir,
	output logic                rd,
	output logic                wr,
	output logic                halted,
	output logic                ir_ld,
	output logic                reg_ld,
	output sm83_pkg::reg_sel_t  reg_dst,
	output logic                reg_src_sel,
	output sm83_pkg::reg_sel_t  rd_sel_a,
	output sm83_pkg::reg_sel_t  rd_sel_b,
	output logic                z_ld,
	output logic                w_ld,
	output sm83_pkg::idu_op_t   idu_op,
	output logic [1:0]          idu_src,
	output logic                pc_ld_idu,
	output logic                pc_ld_wz,
	output logic                sp_ld_idu,
	output logic                sp_ld_hl,
	output sm83_pkg::addr_sel_t addr_sel,
	output logic                pair_ld,
	output logic [1:0]          pair_sel
);

	localparam logic [2:0] st_reset  = 3'd0;   // One idle cycle out of reset
	localparam logic [2:0] st_fetch  = 3'd1;
	localparam logic [2:0] st_decode = 3'd2;
	localparam logic [2:0] st_step2  = 3'd3;
	localparam logic [2:0] st_step3  = 3'd4;
	localparam logic [2:0] st_jump   = 3'd5;
	localparam logic [2:0] st_halt   = 3'd6;

	logic [2:0] state;
	logic [2:0] next_state;
	logic       rd_pc;
	logic       is_halt;
	logic       is_ld_rr;
	logic       is_ld_rn;
	logic       is_ld_hl_r;
	logic       is_incdec;
	logic       is_ldsphl;
	logic       is_jp;

	assign is_halt    = (ir == `SM83_OP_HALT);
	assign is_jp      = (ir == `SM83_OP_JP);
	assign is_ldsphl  = (ir == `SM83_OP_LDSPHL);
	assign is_ld_rr   = (ir.xyz.x == 2'd1) && (ir.xyz.y != 3'd6) && (ir.xyz.z != 3'd6);
	assign is_ld_hl_r = (ir.xyz.x == 2'd1) && (ir.xyz.y == 3'd6) && (ir.xyz.z != 3'd6);
	assign is_ld_rn   = (ir.xyz.x == 2'd0) && (ir.xyz.z == 3'd6) && (ir.xyz.y != 3'd6);
	assign is_incdec  = (ir.xpqz.x == 2'd0) && (ir.xpqz.z == 3'd3);

	always_comb begin
		rd          = 1'b0;
		wr          = 1'b0;
		halted      = 1'b0;
		ir_ld       = 1'b0;
		reg_ld      = 1'b0;
		reg_dst     = sm83_pkg::reg_sel_t'(ir.xyz.y);
		reg_src_sel = `SM83_SRC_DL;
		rd_sel_a    = sm83_pkg::reg_sel_t'(ir.xyz.z);
		rd_sel_b    = sm83_pkg::reg_sel_t'(ir.xyz.z);
		z_ld        = 1'b0;
		w_ld        = 1'b0;
		idu_op      = sm83_pkg::idu_pass;
		idu_src     = `SM83_IDU_SRC_PC;
		pc_ld_idu   = 1'b0;
		pc_ld_wz    = 1'b0;
		sp_ld_idu   = 1'b0;
		sp_ld_hl    = 1'b0;
		addr_sel    = sm83_pkg::addr_pc;
		pair_ld     = 1'b0;
		pair_sel    = ir.xpqz.p;
		rd_pc       = 1'b0;
		next_state  = state;
		case (state)
			st_reset: next_state = st_fetch;
			st_fetch: begin
				rd_pc      = 1'b1;
				next_state = st_decode;
			end
			st_decode: begin
				ir_ld      = 1'b1;   // Opcode arrives on dl now
				next_state = st_fetch;
				if (is_halt) begin
					next_state = st_halt;
				end else if (is_ld_rr) begin
					reg_ld      = 1'b1;
					reg_src_sel = `SM83_SRC_RDA;
				end else if (is_ld_rn || is_jp) begin
					rd_pc      = 1'b1;   // First immediate byte
					next_state = st_step2;
				end else if (is_ld_hl_r) begin
					next_state = st_step2;
				end else if (is_incdec) begin
					idu_op = ir.xpqz.q ? sm83_pkg::idu_dec : sm83_pkg::idu_inc;
					if (ir.xpqz.p == `SM83_PAIR_SP) begin
						idu_src   = `SM83_IDU_SRC_SP;
						sp_ld_idu = 1'b1;
					end else begin
						idu_src = `SM83_IDU_SRC_PAIR;
						pair_ld = 1'b1;
					end
				end else if (is_ldsphl) begin
					sp_ld_hl = 1'b1;
				end
			end
			st_step2: begin
				next_state = st_fetch;
				if (is_jp) begin
					z_ld       = 1'b1;
					rd_pc      = 1'b1;   // High byte
					next_state = st_step3;
				end else if (is_ld_hl_r) begin
					wr       = 1'b1;
					addr_sel = sm83_pkg::addr_hl;
				end else begin
					reg_ld = 1'b1;   // LD r,n immediate
				end
			end
			st_step3: begin
				w_ld       = 1'b1;
				next_state = st_jump;
			end
			st_jump: begin
				pc_ld_wz   = 1'b1;
				addr_sel   = sm83_pkg::addr_wz;
				next_state = st_fetch;
			end
			default: halted = 1'b1;   // Stays until reset
		endcase
		if (rd_pc) begin
			rd        = 1'b1;
			idu_op    = sm83_pkg::idu_inc;
			idu_src   = `SM83_IDU_SRC_PC;
			pc_ld_idu = 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			state <= st_reset;
		else
			state <= next_state;
	end

endmodule

/* verilog/sm83_regs_top.sv */
// SM83 register and bus section, control sequencer joined to the datapath blocks
module sm83_regs_top (
	input  logic        clk,
	input  logic        rst_n,
	input  logic [7:0]  dl,
	output logic [15:0] addr,
	output logic [7:0]  wdata,
	output logic        rd,
	output logic        wr,
	output logic        halted,
	output logic [7:0]  a_out
);

	sm83_pkg::opcode_t   ir;
	sm83_pkg::reg_sel_t  reg_dst;
	sm83_pkg::reg_sel_t  rd_sel_a;
	sm83_pkg::reg_sel_t  rd_sel_b;
	sm83_pkg::idu_op_t   idu_op;
	sm83_pkg::addr_sel_t addr_sel;
	logic                ir_ld;
	logic                reg_ld;
	logic                reg_src_sel;
	logic                z_ld;
	logic                w_ld;
	logic [1:0]          idu_src;
	logic                pc_ld_idu;
	logic                pc_ld_wz;
	logic                sp_ld_idu;
	logic                sp_ld_hl;
	logic                pair_ld;
	logic [1:0]          pair_sel;
	logic [15:0]         pair_q;
	logic [15:0]         hl;
	logic [15:0]         wz;
	logic [15:0]         pc;
	logic [15:0]         sp;
	logic [15:0]         idu_result;

	sm83_control u_control (
		.clk(clk), .rst_n(rst_n), .ir(ir),
		.rd(rd), .wr(wr), .halted(halted),
		.ir_ld(ir_ld), .reg_ld(reg_ld), .reg_dst(reg_dst), .reg_src_sel(reg_src_sel),
		.rd_sel_a(rd_sel_a), .rd_sel_b(rd_sel_b), .z_ld(z_ld), .w_ld(w_ld),
		.idu_op(idu_op), .idu_src(idu_src), .pc_ld_idu(pc_ld_idu), .pc_ld_wz(pc_ld_wz),
		.sp_ld_idu(sp_ld_idu), .sp_ld_hl(sp_ld_hl), .addr_sel(addr_sel),
		.pair_ld(pair_ld), .pair_sel(pair_sel)
	);

	sm83_regfile u_regfile (
		.clk(clk), .rst_n(rst_n), .ir_ld(ir_ld), .dl(dl),
		.reg_ld(reg_ld), .reg_dst(reg_dst), .reg_src_sel(reg_src_sel),
		.rd_sel_a(rd_sel_a), .rd_sel_b(rd_sel_b),
		.pair_ld(pair_ld), .pair_sel(pair_sel), .pair_data(idu_result),
		.ir(ir), .rd_data_a(), .rd_data_b(wdata),   // Port A only feeds register moves
		.pair_q(pair_q), .hl(hl), .a_out(a_out)
	);

	sm83_temp_regs u_temp_regs (
		.clk(clk), .rst_n(rst_n), .z_ld(z_ld), .w_ld(w_ld), .dl(dl), .wz(wz)
	);

	sm83_idu u_idu (
		.idu_op(idu_op), .pc(pc), .sp(sp), .pair_q(pair_q),
		.idu_src(idu_src), .result(idu_result)
	);

	sm83_sp_pc u_sp_pc (
		.clk(clk), .rst_n(rst_n),
		.pc_ld_idu(pc_ld_idu), .pc_ld_wz(pc_ld_wz),
		.sp_ld_idu(sp_ld_idu), .sp_ld_hl(sp_ld_hl), .addr_sel(addr_sel),
		.idu_result(idu_result), .wz(wz), .hl(hl),
		.pc(pc), .sp(sp), .addr(addr)
	);

endmodule

/* testbench/sm83_regs_properties.sv */
// SM83 register section bus properties, bound to the top level
module sm83_regs_properties (
	input logic clk,
	input logic rst_n,
	input logic rd,
	input logic wr,
	input logic halted
);

	// Read and write strobes are exclusive
	a_rd_wr_exclusive: assert property (@(posedge clk) !(rd && wr))
		else $error("rd and wr high in the same cycle");

	// Quiet bus once reset has been seen for a full cycle
	a_quiet_in_reset: assert property (@(posedge clk) (!rst_n && !$past(rst_n)) |-> (!rd && !wr))
		else $error("bus strobe during reset");

	a_no_rd_halted: assert property (@(posedge clk) disable iff (!rst_n) halted |-> !rd)
		else $error("rd while halted");

endmodule

bind sm83_regs_top sm83_regs_properties i_properties (
	.clk(clk),
	.rst_n(rst_n),
	.rd(rd),
	.wr(wr),
	.halted(halted)
);

/* testbench/sm83_regs_checker.sv */
// SM83 register section reference model that compares bus traffic and register A
`include "sm83_consts.svh"

module sm83_regs_checker (
	input  logic        clk,
	input  logic        rst_n,
	input  logic [7:0]  dl,
	input  logic [15:0] addr,
	input  logic [7:0]  wdata,
	input  logic        rd,
	input  logic        wr,
	input  logic        halted,
	input  logic [7:0]  a_out,
	input  logic        test_done,
	input  logic [7:0]  test_id,
	input  logic [7:0]  exp_rd,
	input  logic [7:0]  exp_wr,
	input  logic        timed_out,
	output int          fail_count,
	output int          error_count
);

	localparam logic [1:0] role_op  = 2'd0;   // Next byte is an opcode
	localparam logic [1:0] role_imm = 2'd1;
	localparam logic [1:0] role_lo  = 2'd2;
	localparam logic [1:0] role_hi  = 2'd3;

	logic [7:0]  regs [8];   // Opcode order with slot 6 unused
	logic [15:0] m_pc;
	logic [15:0] m_sp;
	logic [1:0]  role;
	logic [2:0]  imm_dst;
	logic [7:0]  jp_lo;
	logic        byte_due;   // dl carries a byte this cycle
	logic        m_halted;
	logic        halt_seen;
	logic        wr_due;
	logic [15:0] wr_addr;
	logic [7:0]  wr_data;
	int          n_rd;
	int          n_wr;
	int          test_errors;
	int          n_fail = 0;
	int          n_error = 0;

	assign fail_count  = n_fail;
	assign error_count = n_error;

	task automatic report(input string msg);
		$display("Error %0t: %s", $time, msg);
		n_error++;
		test_errors++;
	endtask

	task automatic reset_model();
		for (int i = 0; i < 8; i++)
			regs[i] = 8'h00;
		m_pc        = `SM83_PC_RESET;
		m_sp        = `SM83_SP_RESET;
		role        = role_op;
		imm_dst     = 3'd0;
		jp_lo       = 8'h00;
		byte_due    = 1'b0;
		m_halted    = 1'b0;
		halt_seen   = 1'b0;
		wr_due      = 1'b0;
		wr_addr     = 16'h0000;
		wr_data     = 8'h00;
		n_rd        = 0;
		n_wr        = 0;
		test_errors = 0;
	endtask

	function automatic logic [15:0] pair_get(input logic [1:0] p);
		case (p)
			2'd0:    pair_get = {regs[0], regs[1]};
			2'd1:    pair_get = {regs[2], regs[3]};
			2'd2:    pair_get = {regs[4], regs[5]};
			default: pair_get = m_sp;
		endcase
	endfunction

	task automatic pair_set(input logic [1:0] p, input logic [15:0] v);
		case (p)
			2'd0:    {regs[0], regs[1]} = v;
			2'd1:    {regs[2], regs[3]} = v;
			2'd2:    {regs[4], regs[5]} = v;
			default: m_sp = v;
		endcase
	endtask

	task automatic run_opcode(input logic [7:0] op);
		logic [1:0] x;
		logic [2:0] y;
		logic [2:0] z;
		x = op[7:6];
		y = op[5:3];
		z = op[2:0];
		if (op == `SM83_OP_HALT) begin
			m_halted = 1'b1;
		end else if (op == `SM83_OP_JP) begin
			role = role_lo;
		end else if (op == `SM83_OP_LDSPHL) begin
			m_sp = {regs[4], regs[5]};
		end else if (x == 2'd1 && y != 3'd6 && z != 3'd6) begin
			regs[y] = regs[z];   // LD r,r'
		end else if (x == 2'd1 && y == 3'd6) begin
			wr_due  = 1'b1;   // LD (HL),r
			wr_addr = {regs[4], regs[5]};
			wr_data = regs[z];
		end else if (x == 2'd0 && z == 3'd6 && y != 3'd6) begin
			role    = role_imm;
			imm_dst = y;
		end else if (x == 2'd0 && z == 3'd3) begin
			if (op[3])
				pair_set(op[5:4], pair_get(op[5:4]) - 16'd1);
			else
				pair_set(op[5:4], pair_get(op[5:4]) + 16'd1);
		end
	endtask

	task automatic take_byte(input logic [7:0] b);
		case (role)
			role_op:  run_opcode(b);
			role_imm: begin
				regs[imm_dst] = b;
				role          = role_op;
			end
			role_lo:  begin
				jp_lo = b;
				role  = role_hi;
			end
			default:  begin
				m_pc = {b, jp_lo};   // Low byte came first
				role = role_op;
			end
		endcase
	endtask

	// Ports are settled at the falling edge
	always @(negedge clk) begin
		if (!rst_n) begin
			reset_model();
		end else begin
			if (byte_due) begin
				byte_due = 1'b0;
				take_byte(dl);
			end
			if (rd) begin
				n_rd++;
				if (m_halted)
					report("rd after HALT");
				else if (addr !== m_pc)
					report($sformatf("rd addr %h, expected %h", addr, m_pc));
				m_pc     = m_pc + 16'd1;
				byte_due = 1'b1;
			end
			if (wr) begin
				n_wr++;
				if (!wr_due)
					report("wr without a store instruction");
				else if (addr !== wr_addr || wdata !== wr_data)
					report($sformatf("wr %h:%h, expected %h:%h",
						addr, wdata, wr_addr, wr_data));
				wr_due = 1'b0;
			end
			if (halted && !halt_seen) begin
				halt_seen = 1'b1;
				if (!m_halted)
					report("halted without a HALT opcode");
				if (a_out !== regs[7])
					report($sformatf("a_out %h, expected %h", a_out, regs[7]));
			end
		end
		if (test_done) begin
			if (n_rd != int'(exp_rd) || n_wr != int'(exp_wr))
				report($sformatf("saw %0d rd and %0d wr, expected %0d and %0d",
					n_rd, n_wr, exp_rd, exp_wr));
			if (test_errors != 0 || timed_out || !halt_seen) begin
				n_fail++;
				$display("test %0d: FAILED, %0d rd, %0d wr", test_id, n_rd, n_wr);
			end else begin
				$display("test %0d: ok, %0d rd, %0d wr", test_id, n_rd, n_wr);
			end
		end
	end

endmodule

/* testbench/sm83_regs_tb.sv */
// SM83 register section testbench that runs a table of small programs to HALT
`include "sm83_consts.svh"

module sm83_regs_tb;

	localparam int n_tests      = 6;
	localparam int row_bytes    = 24;
	localparam int halt_timeout = 400;   // Cycles
	localparam int quiet_cycles = 12;    // Watch for rd after HALT

	logic        clk;
	logic        rst_n;
	logic [7:0]  dl = 8'h00;
	logic [15:0] addr;
	logic [7:0]  wdata;
	logic        rd;
	logic        wr;
	logic        halted;
	logic [7:0]  a_out;
	logic        test_done;
	logic [7:0]  test_id;
	logic [7:0]  exp_rd;
	logic [7:0]  exp_wr;
	logic        timed_out;
	int          fail_count;
	int          error_count;

	logic [191:0] prog_tab [n_tests];   // First byte in the top bits
	logic [23:0]  imm_mask [n_tests];   // Byte i is random where bit i is set
	logic [7:0]   rd_tab [n_tests];
	logic [7:0]   wr_tab [n_tests];
	logic [7:0]   prog [row_bytes];
	logic [31:0]  rng_state;
	logic         rd_q = 1'b0;
	logic [15:0]  addr_q = 16'h0000;

	sm83_regs_top i_dut (
		.clk(clk), .rst_n(rst_n), .dl(dl), .addr(addr), .wdata(wdata),
		.rd(rd), .wr(wr), .halted(halted), .a_out(a_out)
	);

	sm83_regs_checker i_checker (
		.clk(clk), .rst_n(rst_n), .dl(dl), .addr(addr), .wdata(wdata),
		.rd(rd), .wr(wr), .halted(halted), .a_out(a_out),
		.test_done(test_done), .test_id(test_id), .exp_rd(exp_rd), .exp_wr(exp_wr),
		.timed_out(timed_out), .fail_count(fail_count), .error_count(error_count)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] v;
		v = s ^ (s << 13);
		v = v ^ (v >> 17);
		v = v ^ (v << 5);
		return v;
	endfunction

	// Program bytes at low addresses and a pattern of the full address above
	function automatic logic [7:0] byte_at(input logic [15:0] a);
		if (a < 16'(row_bytes))
			return prog[a[4:0]];
		return a[15:8] ^ a[7:0] ^ 8'h3c;
	endfunction

	always @(negedge clk) begin
		rd_q   = rd;
		addr_q = addr;
	end

	// Memory answers in the cycle after rd
	always @(posedge clk) begin
		#2;
		if (rd_q)
			dl = byte_at(addr_q);
	end

	task automatic load_table();
		// NOPs, then HALT
		prog_tab[0] = {8'h00, 8'h00, 8'h00, `SM83_OP_HALT, {20{8'h00}}};
		imm_mask[0] = 24'h000000;
		rd_tab[0]   = 8'd4;
		wr_tab[0]   = 8'd0;
		// LD B,n  LD A,B  LD H,n  LD L,n  LD (HL),A  LD C,A  LD (HL),C
		prog_tab[1] = {8'h06, 8'h00, 8'h78, 8'h26, 8'h00, 8'h2e, 8'h00, 8'h77,
			8'h4f, 8'h71, `SM83_OP_HALT, {13{8'h00}}};
		imm_mask[1] = 24'h000052;
		rd_tab[1]   = 8'd11;
		wr_tab[1]   = 8'd2;
		// HL and BC wrap both ways
		prog_tab[2] = {8'h26, 8'hff, 8'h2e, 8'hff, 8'h23, 8'h77, 8'h2b, 8'h77,
			8'h06, 8'hff, 8'h0e, 8'hff, 8'h03, 8'h60, 8'h69, 8'h77,
			`SM83_OP_HALT, {7{8'h00}}};
		imm_mask[2] = 24'h000000;
		rd_tab[2]   = 8'd17;
		wr_tab[2]   = 8'd3;
		// DE wraps down, then SP moves
		prog_tab[3] = {8'h16, 8'h00, 8'h1e, 8'h00, 8'h1b, 8'h62, 8'h6b, 8'h73,
			`SM83_OP_LDSPHL, 8'h33, 8'h3b, `SM83_OP_HALT, {12{8'h00}}};
		imm_mask[3] = 24'h000000;
		rd_tab[3]   = 8'd12;
		wr_tab[3]   = 8'd1;
		// JP 0010 and LD A,n there
		prog_tab[4] = {`SM83_OP_JP, 8'h10, 8'h00, {13{8'h00}},
			8'h3e, 8'h00, `SM83_OP_HALT, {5{8'h00}}};
		imm_mask[4] = 24'h020000;
		rd_tab[4]   = 8'd6;
		wr_tab[4]   = 8'd0;
		// Opcodes outside the subset, then JP 0014 into a move chain
		prog_tab[5] = {8'h3e, 8'h00, 8'h80, 8'h07, `SM83_OP_JP, 8'h14, 8'h00,
			{13{8'h00}}, 8'h47, 8'h50, 8'h7a, `SM83_OP_HALT};
		imm_mask[5] = 24'h000002;
		rd_tab[5]   = 8'd11;
		wr_tab[5]   = 8'd0;
	endtask

	task automatic load_program(input int row);
		for (int i = 0; i < row_bytes; i++) begin
			prog[i] = prog_tab[row][191 - 8 * i -: 8];
			if (imm_mask[row][i]) begin
				rng_state = xorshift32(rng_state);
				prog[i]   = rng_state[7:0];
			end
		end
	endtask

	task automatic step();
		@(posedge clk);
		#2;
	endtask

	task automatic apply_reset();
		rst_n = 1'b0;
		repeat (8) step();
		rst_n = 1'b1;
	endtask

	task automatic wait_halted(output logic ok);
		int n;
		n = 0;
		while (!halted && n < halt_timeout) begin
			step();
			n++;
		end
		ok = halted;
	endtask

	initial begin
		logic ok;
		rst_n     = 1'b0;
		test_done = 1'b0;
		test_id   = 8'd0;
		exp_rd    = 8'd0;
		exp_wr    = 8'd0;
		timed_out = 1'b0;
		rng_state = 32'hcca0_f259;
		load_table();
		for (int t = 0; t < n_tests; t++) begin
			load_program(t);
			timed_out = 1'b0;
			apply_reset();
			wait_halted(ok);
			if (!ok)
				$display("timeout waiting for halted in test %0d", t);
			timed_out = !ok;
			repeat (quiet_cycles) step();
			test_id   = t[7:0];
			exp_rd    = rd_tab[t];
			exp_wr    = wr_tab[t];
			test_done = 1'b1;
			step();
			test_done = 1'b0;
		end
		$display("%0d tests run, %0d failed, %0d errors", n_tests, fail_count, error_count);
		if (fail_count == 0 && error_count == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

/* sm83_regs.f */
+incdir+verilog
verilog/sm83_pkg.sv
verilog/sm83_regfile.sv
verilog/sm83_temp_regs.sv
verilog/sm83_sp_pc.sv
verilog/sm83_idu.sv
verilog/sm83_control.sv
verilog/sm83_regs_top.sv
testbench/sm83_regs_properties.sv
testbench/sm83_regs_checker.sv
testbench/sm83_regs_tb.sv

/* Makefile */
# Verilator build and run for the SM83 register section testbench

VERILATOR ?= verilator
TOP       ?= sm83_regs_tb
FILELIST  ?= sm83_regs.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^all tests passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
